// File: Bender.yml
package:
  name: conv_pool

sources:
  - files:
      - logic/conv_pkg.sv
      - logic/conv_sequencer.sv
      - logic/window_fetch.sv
      - logic/conv_mac.sv
      - logic/max_pool.sv
      - logic/conv_top.sv
  - target: test
    files:
      - verification/clock_gen.sv
      - verification/conv_tb.sv

// File: conv_pool.f
logic/conv_pkg.sv
logic/conv_sequencer.sv
logic/window_fetch.sv
logic/conv_mac.sv
logic/max_pool.sv
logic/conv_top.sv
verification/clock_gen.sv
verification/conv_tb.sv

// File: logic/conv_mac.sv
`timescale 1ns/100ps

module conv_mac import conv_pkg::*; (
	input logic clk,
	input logic reset,
	input logic tap_valid,
	input logic [3:0] tap_index,
	input pixel_t tap_data,
	output logic res_valid,
	output pixel_t res_data
);

	localparam int prod_bits = 2 * data_bits;
	// products carry 2*frac_bits fraction bits
	localparam logic signed [acc_bits-1:0] bias_acc = acc_bits'(bias_w) <<< frac_bits;
	localparam logic signed [acc_bits-1:0] round_half = acc_bits'(1) <<< (frac_bits - 1);

	logic prod_valid;
	logic [3:0] prod_index;
	logic signed [prod_bits-1:0] prod_q;
	logic signed [acc_bits-1:0] acc;
	logic signed [acc_bits-1:0] sum;
	logic signed [acc_bits-1:0] rounded;
	pixel_t relu;

	always_comb begin
		if (prod_index == 4'd0)
			sum = acc_bits'(prod_q);
		else
			sum = acc + acc_bits'(prod_q);
		if (prod_index == 4'd8)
			sum = sum + bias_acc;
		rounded = sum + round_half;
		// keep 4 integer and 16 fraction bits
		if (rounded[acc_bits-1])
			relu = '0;
		else
			relu = rounded[frac_bits+data_bits-1:frac_bits];
	end

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			prod_valid <= 1'b0;
			res_valid <= 1'b0;
		end else begin
			prod_valid <= tap_valid;
			res_valid <= prod_valid && prod_index == 4'd8;
			if (tap_valid) begin
				prod_index <= tap_index;
				prod_q <= tap_data * kernel_w[tap_index];
			end
			if (prod_valid) begin
				acc <= sum;
				if (prod_index == 4'd8)
					res_data <= relu;
			end
		end
	end

endmodule

// File: logic/conv_pkg.sv
package conv_pkg;

	localparam int data_bits = 20;    // Q4.16 signed
	localparam int frac_bits = 16;
	localparam int acc_bits = 44;
	localparam int max_img_bits = 6;
	localparam int addr_bits = 2 * max_img_bits;

	typedef logic signed [data_bits-1:0] pixel_t;

	typedef struct packed {
		logic [max_img_bits-1:0] row;
		logic [max_img_bits-1:0] col;
	} pixel_rc_t;

	// same 12 bits seen as a flat index or as row/col
	typedef union packed {
		logic [addr_bits-1:0] flat;
		pixel_rc_t rc;
	} pixel_addr_u;

	// 3x3 kernel, row-major from top-left
	localparam pixel_t kernel_w [0:8] = '{
		20'h0A89E, 20'h092D5, 20'h06D43,
		20'h01004, 20'hF8F71, 20'hF6E54,
		20'hFA6D7, 20'hFC834, 20'hFAC19
	};

	localparam pixel_t bias_w = 20'h01310;

	typedef enum logic [2:0] {
		csel_none = 3'd0,
		csel_l0 = 3'd1,
		csel_l1 = 3'd3
	} csel_t;

endpackage

// File: logic/conv_sequencer.sv
`timescale 1ns/100ps

module conv_sequencer import conv_pkg::*; #(
	parameter int img_bits = 6
) (
	input logic clk,
	input logic reset,
	input logic ready,
	output logic busy,
	output logic win_start,
	output logic [img_bits-1:0] win_row,
	output logic [img_bits-1:0] win_col,
	input logic res_valid,
	input pixel_t res_data,
	output logic pool_start,
	output logic [img_bits-1:0] pool_row,
	output logic [img_bits-1:0] pool_col,
	input logic pool_valid,
	input pixel_t pool_data,
	output logic cwr,
	output logic [addr_bits-1:0] caddr_wr,
	output pixel_t cdata_wr,
	output csel_t csel
);

	typedef enum logic [1:0] {st_idle, st_convolve, st_drain, st_pool} state_t;

	localparam logic [img_bits-1:0] last_idx = '1;
	localparam logic [img_bits-1:0] last_blk = img_bits'(2 ** img_bits - 2);

	state_t state;
	logic [3:0] slot;    // 9 cycles per window
	logic [img_bits-1:0] wr_row;
	logic [img_bits-1:0] wr_col;
	pixel_addr_u wr_addr;
	pixel_addr_u blk_addr;

	assign win_start = (state == st_convolve) && (slot == 4'd0);

	always_comb begin
		wr_addr = '0;
		wr_addr.rc.row = max_img_bits'(wr_row);
		wr_addr.rc.col = max_img_bits'(wr_col);
		blk_addr = '0;
		blk_addr.rc.row = max_img_bits'(pool_row);
		blk_addr.rc.col = max_img_bits'(pool_col);
	end

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			state <= st_idle;
			busy <= 1'b0;
			slot <= '0;
			win_row <= '0;
			win_col <= '0;
			wr_row <= '0;
			wr_col <= '0;
			pool_row <= '0;
			pool_col <= '0;
			pool_start <= 1'b0;
			cwr <= 1'b0;
			csel <= csel_none;
		end else begin
			cwr <= 1'b0;
			pool_start <= 1'b0;
			if (res_valid) begin
				// results come back in raster order
				cwr <= 1'b1;
				caddr_wr <= wr_addr.flat;
				cdata_wr <= res_data;
				csel <= csel_l0;
				wr_col <= wr_col + 1'b1;
				if (wr_col == last_idx)
					wr_row <= wr_row + 1'b1;
			end
			if (pool_valid) begin
				cwr <= 1'b1;
				caddr_wr <= blk_addr.flat;
				cdata_wr <= pool_data;
				csel <= csel_l1;
			end
			case (state)
				st_idle: if (ready) begin
					state <= st_convolve;
					busy <= 1'b1;
					slot <= '0;
					win_row <= '0;
					win_col <= '0;
					wr_row <= '0;
					wr_col <= '0;
					pool_row <= '0;
					pool_col <= '0;
					csel <= csel_l0;
				end
				st_convolve: if (slot == 4'd8) begin
					slot <= '0;
					if (win_row == last_idx && win_col == last_idx) begin
						state <= st_drain;
					end else begin
						win_col <= win_col + 1'b1;
						if (win_col == last_idx)
							win_row <= win_row + 1'b1;
					end
				end else begin
					slot <= slot + 1'b1;
				end
				st_drain: if (res_valid && wr_row == last_idx && wr_col == last_idx)
					state <= st_pool;
				st_pool: if (cwr) begin
					if (csel == csel_l0) begin
						pool_start <= 1'b1;    // last layer-0 word is in
					end else if (pool_row == last_blk && pool_col == last_blk) begin
						state <= st_idle;
						busy <= 1'b0;
						csel <= csel_none;
					end else begin
						pool_start <= 1'b1;
						csel <= csel_l0;
						pool_col <= pool_col + 2'd2;
						if (pool_col == last_blk)
							pool_row <= pool_row + 2'd2;
					end
				end
				default: state <= st_idle;
			endcase
		end
	end

endmodule

// File: logic/conv_top.sv
`timescale 1ns/100ps

module conv_top import conv_pkg::*; #(
	parameter int img_bits = 6
) (
	input logic clk,
	input logic reset,
	input logic ready,
	output logic busy,
	output logic [addr_bits-1:0] iaddr,
	input pixel_t idata,
	output logic cwr,
	output logic [addr_bits-1:0] caddr_wr,
	output pixel_t cdata_wr,
	output logic crd,
	output logic [addr_bits-1:0] caddr_rd,
	input pixel_t cdata_rd,
	output csel_t csel
);

	logic win_start;
	logic [img_bits-1:0] win_row;
	logic [img_bits-1:0] win_col;
	logic tap_valid;
	logic [3:0] tap_index;
	pixel_t tap_data;
	logic res_valid;
	pixel_t res_data;
	logic pool_start;
	logic [img_bits-1:0] pool_row;
	logic [img_bits-1:0] pool_col;
	logic pool_valid;
	pixel_t pool_data;

	conv_sequencer #(.img_bits(img_bits)) u_seq (
		.clk(clk), .reset(reset), .ready(ready), .busy(busy),
		.win_start(win_start), .win_row(win_row), .win_col(win_col),
		.res_valid(res_valid), .res_data(res_data),
		.pool_start(pool_start), .pool_row(pool_row), .pool_col(pool_col),
		.pool_valid(pool_valid), .pool_data(pool_data),
		.cwr(cwr), .caddr_wr(caddr_wr), .cdata_wr(cdata_wr), .csel(csel)
	);

	window_fetch #(.img_bits(img_bits)) u_fetch (
		.clk(clk), .reset(reset),
		.win_start(win_start), .win_row(win_row), .win_col(win_col),
		.iaddr(iaddr), .idata(idata),
		.tap_valid(tap_valid), .tap_index(tap_index), .tap_data(tap_data)
	);

	conv_mac u_mac (
		.clk(clk), .reset(reset),
		.tap_valid(tap_valid), .tap_index(tap_index), .tap_data(tap_data),
		.res_valid(res_valid), .res_data(res_data)
	);

	// reads only run in the pool phase, while csel holds layer 0
	max_pool #(.img_bits(img_bits)) u_pool (
		.clk(clk), .reset(reset),
		.pool_start(pool_start), .pool_row(pool_row), .pool_col(pool_col),
		.crd(crd), .caddr_rd(caddr_rd), .cdata_rd(cdata_rd),
		.pool_valid(pool_valid), .pool_data(pool_data)
	);

endmodule

// File: logic/max_pool.sv
`timescale 1ns/100ps

module max_pool import conv_pkg::*; #(
	parameter int img_bits = 6
) (
	input logic clk,
	input logic reset,
	input logic pool_start,
	input logic [img_bits-1:0] pool_row,
	input logic [img_bits-1:0] pool_col,
	output logic crd,
	output logic [addr_bits-1:0] caddr_rd,
	input pixel_t cdata_rd,
	output logic pool_valid,
	output pixel_t pool_data
);

	logic active;
	logic accept;
	logic [1:0] rd_cnt;    // read on the port this cycle
	logic [1:0] rd_k;
	logic [img_bits-1:0] blk_row;
	logic [img_bits-1:0] blk_col;
	logic [img_bits-1:0] rd_row;
	logic [img_bits-1:0] rd_col;
	pixel_addr_u rd_addr;
	logic data_valid;
	logic [1:0] data_idx;
	pixel_t max_q;

	assign accept = pool_start && !active;
	assign rd_k = accept ? 2'd0 : rd_cnt + 1'b1;
	assign rd_row = accept ? pool_row : blk_row;
	assign rd_col = accept ? pool_col : blk_col;

	always_comb begin
		rd_addr = '0;
		rd_addr.rc.row = max_img_bits'(rd_row + img_bits'(rd_k[1]));
		rd_addr.rc.col = max_img_bits'(rd_col + img_bits'(rd_k[0]));
	end

	// first word of a block seeds the max
	assign pool_data = (data_idx == 2'd0 || cdata_rd > max_q) ? cdata_rd : max_q;
	assign pool_valid = data_valid && data_idx == 2'd3;

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			active <= 1'b0;
			rd_cnt <= '0;
			crd <= 1'b0;
			caddr_rd <= '0;
			data_valid <= 1'b0;
		end else begin
			data_valid <= crd;
			data_idx <= rd_cnt;
			if (data_valid)
				max_q <= pool_data;
			if (accept || (active && rd_cnt != 2'd3)) begin
				active <= 1'b1;
				rd_cnt <= rd_k;
				crd <= 1'b1;
				caddr_rd <= rd_addr.flat;
			end else begin
				active <= 1'b0;
				crd <= 1'b0;
			end
			if (accept) begin
				blk_row <= pool_row;
				blk_col <= pool_col;
			end
		end
	end

endmodule

// File: logic/window_fetch.sv
`timescale 1ns/100ps

module window_fetch import conv_pkg::*; #(
	parameter int img_bits = 6
) (
	input logic clk,
	input logic reset,
	input logic win_start,
	input logic [img_bits-1:0] win_row,
	input logic [img_bits-1:0] win_col,
	output logic [addr_bits-1:0] iaddr,
	input pixel_t idata,
	output logic tap_valid,
	output logic [3:0] tap_index,
	output pixel_t tap_data
);

	localparam int img_size = 2 ** img_bits;

	logic active;
	logic [3:0] cur_tap;    // tap on iaddr this cycle
	logic cur_pad;
	logic pad_q;
	logic [img_bits-1:0] ctr_row;
	logic [img_bits-1:0] ctr_col;
	logic accept;
	logic [3:0] next_tap;
	logic [img_bits-1:0] base_row;
	logic [img_bits-1:0] base_col;
	logic nxt_pad;
	pixel_addr_u nxt_addr;

	// a new window may start while tap 8 is out
	assign accept = win_start && (!active || cur_tap == 4'd8);
	assign next_tap = accept ? 4'd0 : cur_tap + 1'b1;
	assign base_row = accept ? win_row : ctr_row;
	assign base_col = accept ? win_col : ctr_col;

	always_comb begin
		int nr;
		int nc;
		nr = int'(base_row) + int'(next_tap) / 3 - 1;
		nc = int'(base_col) + int'(next_tap) % 3 - 1;
		nxt_pad = (nr < 0) || (nr >= img_size) || (nc < 0) || (nc >= img_size);
		nxt_addr = '0;    // padded taps read address 0
		if (!nxt_pad) begin
			nxt_addr.rc.row = max_img_bits'(nr);
			nxt_addr.rc.col = max_img_bits'(nc);
		end
	end

	assign tap_data = pad_q ? '0 : idata;

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			active <= 1'b0;
			cur_tap <= '0;
			iaddr <= '0;
			tap_valid <= 1'b0;
		end else begin
			tap_valid <= active;
			tap_index <= cur_tap;
			pad_q <= cur_pad;
			if (accept) begin
				active <= 1'b1;
				ctr_row <= win_row;
				ctr_col <= win_col;
			end else if (cur_tap == 4'd8) begin
				active <= 1'b0;
			end
			if (accept || (active && cur_tap != 4'd8)) begin
				cur_tap <= next_tap;
				cur_pad <= nxt_pad;
				iaddr <= nxt_addr.flat;
			end
		end
	end

endmodule

// File: verification/clock_gen.sv
`timescale 1ns/100ps

module clock_gen #(
	parameter real period = 100.0,
	parameter int reset_cycles = 3
) (
	output logic clk,
	output logic reset
);

	initial begin
		clk = 1'b0;
		forever #(period / 2.0) clk = ~clk;
	end

	initial begin
		reset = 1'b1;
		repeat (reset_cycles) @(posedge clk);
		#10 reset = 1'b0;    // released off the edge
	end

endmodule

// File: verification/conv_golden.mem
// per image: 16 pixels raster, 16 layer-0 words, 4 layer-1 words (block order)
// Q4.16 hex, 1.0 is 10000
// image 0 pixels
00000
00000
00000
00000
00000
10000
00000
00000
00000
00000
10000
00000
00000
00000
00000
00000
// image 0 layer 0
00000
00000
00000
01310
00000
00000
00000
00000
08053
01439
04B1F
02314
01310
08053
0A5E5
0BBAE
// image 0 layer 1
00000
01310
08053
0BBAE
// image 1 pixels
10000
10000
10000
10000
10000
10000
10000
10000
10000
10000
10000
10000
10000
10000
10000
10000
// image 1 layer 0
00000
00000
00000
00000
00000
00000
00000
05D03
00000
00000
00000
05D03
010ED
0C98F
0C98F
0EDF8
// image 1 layer 1
00000
05D03
0C98F
0EDF8

// File: verification/conv_tb.sv
`timescale 1ns/100ps

module conv_tb import conv_pkg::*; ();

	localparam int img_bits = 2;
	localparam int img_side = 2 ** img_bits;
	localparam int n_pix = img_side * img_side;
	localparam int n_blk = n_pix / 4;
	localparam int n_img = 2;
	localparam int img_words = 2 * n_pix + n_blk;    // image, layer 0, layer 1
	localparam int cycle_limit = n_img * (n_pix * 12 + n_blk * 8 + 20) * 2;

	logic clk;
	logic reset;
	logic ready;
	logic busy;
	logic [addr_bits-1:0] iaddr;
	pixel_t idata;
	logic cwr;
	logic [addr_bits-1:0] caddr_wr;
	pixel_t cdata_wr;
	logic crd;
	logic [addr_bits-1:0] caddr_rd;
	pixel_t cdata_rd;
	csel_t csel;

	logic [data_bits-1:0] gold [0:n_img*img_words-1];
	pixel_t l0_mem [0:n_pix-1];
	logic [addr_bits-1:0] iaddr_q;
	logic [addr_bits-1:0] caddr_q;
	logic crd_q;
	int cur_img;
	int l0_cnt;
	int l1_cnt;
	int errors;
	int cycles;

	clock_gen #(.period(100.0), .reset_cycles(3)) u_clk (.clk(clk), .reset(reset));

	conv_top #(.img_bits(img_bits)) u_dut (
		.clk(clk), .reset(reset), .ready(ready), .busy(busy),
		.iaddr(iaddr), .idata(idata),
		.cwr(cwr), .caddr_wr(caddr_wr), .cdata_wr(cdata_wr),
		.crd(crd), .caddr_rd(caddr_rd), .cdata_rd(cdata_rd),
		.csel(csel)
	);

	task automatic fail_run();
		errors++;
		$display("Some tests failed");
		$fatal(1);
	endtask

	task automatic check_pixel(input string name, input pixel_t got, input pixel_t exp);
		if (got !== exp) begin
			$display("ERROR %s got %h expected %h", name, got, exp);
			fail_run();
		end
	endtask

	task automatic check_addr(input string name, input pixel_addr_u got,
			input pixel_addr_u exp);
		if (got.flat !== exp.flat) begin
			$display("ERROR %s got %h expected %h", name, got.flat, exp.flat);
			fail_run();
		end
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			$display("ERROR %s got %h expected %h", name, got, exp);
			fail_run();
		end
	endtask

	task automatic check_sel(input string name, input csel_t got, input csel_t exp);
		if (got !== exp) begin
			$display("ERROR %s got %h expected %h", name, got, exp);
			fail_run();
		end
	endtask

	// flat port address to raster index of the small image
	function automatic int pix_index(input logic [addr_bits-1:0] a);
		pixel_addr_u u;
		u.flat = a;
		return int'(u.rc.row) * img_side + int'(u.rc.col);
	endfunction

	function automatic pixel_t block_max(input int img, input int blk);
		int r;
		int c;
		pixel_t m;
		pixel_t v;
		r = 2 * (blk / (img_side / 2));
		c = 2 * (blk % (img_side / 2));
		m = gold[img * img_words + n_pix + r * img_side + c];
		for (int k = 1; k < 4; k++) begin
			v = gold[img * img_words + n_pix + (r + k / 2) * img_side + c + k % 2];
			if (v > m)
				m = v;
		end
		return m;
	endfunction

	// memory models and write monitor, all off the edge
	always @(posedge clk) begin
		pixel_addr_u got_a;
		pixel_addr_u exp_a;
		int base;
		#10;
		base = cur_img * img_words;
		idata = gold[base + pix_index(iaddr_q)];
		iaddr_q = iaddr;
		cdata_rd = crd_q ? l0_mem[pix_index(caddr_q)] : 'x;    // x unless a read was issued
		caddr_q = caddr_rd;
		crd_q = crd;
		if (!reset && crd && (!busy || csel != csel_l0)) begin
			$display("layer read while idle or with layer 0 not selected");
			fail_run();
		end
		if (!reset && cwr) begin
			got_a.flat = caddr_wr;
			exp_a = '0;
			if (!busy) begin
				$display("layer write seen while busy was low");
				fail_run();
			end
			if (csel == csel_l0) begin
				if (l0_cnt >= n_pix) begin
					$display("more layer-0 writes than pixels");
					fail_run();
				end
				exp_a.rc.row = max_img_bits'(l0_cnt / img_side);    // raster order
				exp_a.rc.col = max_img_bits'(l0_cnt % img_side);
				check_addr("caddr_wr", got_a, exp_a);
				check_pixel("cdata_wr", cdata_wr, gold[base + n_pix + l0_cnt]);
				l0_mem[l0_cnt] = cdata_wr;
				l0_cnt++;
			end else if (csel == csel_l1) begin
				if (l0_cnt != n_pix || l1_cnt >= n_blk) begin
					$display("layer-1 write out of sequence");
					fail_run();
				end
				exp_a.rc.row = max_img_bits'(2 * (l1_cnt / (img_side / 2)));
				exp_a.rc.col = max_img_bits'(2 * (l1_cnt % (img_side / 2)));
				check_addr("caddr_wr", got_a, exp_a);
				check_pixel("cdata_wr", cdata_wr, block_max(cur_img, l1_cnt));
				check_pixel("cdata_wr", cdata_wr, gold[base + 2 * n_pix + l1_cnt]);
				l1_cnt++;
			end else begin
				$display("layer write with no layer selected");
				fail_run();
			end
		end
	end

	always @(posedge clk) begin
		cycles++;
		if (cycles > cycle_limit) begin
			$display("run did not finish within %0d cycles", cycle_limit);
			fail_run();
		end
	end

	task automatic run_image(input int img);
		cur_img = img;
		l0_cnt = 0;
		l1_cnt = 0;
		@(posedge clk);
		#10 ready = 1'b1;
		@(posedge clk);
		#10 ready = 1'b0;
		while (!busy) begin
			@(posedge clk);
			#10;
		end
		while (busy) begin
			@(posedge clk);
			#10;
		end
		if (l0_cnt != n_pix || l1_cnt != n_blk) begin
			$display("busy fell before all layer writes were done");
			fail_run();
		end
		check_sel("csel", csel, csel_none);
	endtask

	initial begin
		ready = 1'b0;
		idata = '0;
		cdata_rd = '0;
		iaddr_q = '0;
		caddr_q = '0;
		crd_q = 1'b0;
		cur_img = 0;
		l0_cnt = 0;
		l1_cnt = 0;
		errors = 0;
		cycles = 0;
		for (int i = 0; i < n_pix; i++)
			l0_mem[i] = '0;
		$readmemh("verification/conv_golden.mem", gold);
		@(posedge clk);
		while (reset) @(posedge clk);
		// idle outputs before any start
		repeat (3) begin
			@(posedge clk);
			#10;
			check_bit("busy", busy, 1'b0);
			check_bit("cwr", cwr, 1'b0);
			check_bit("crd", crd, 1'b0);
			check_sel("csel", csel, csel_none);
		end
		for (int k = 0; k < n_img; k++)
			run_image(k);
		repeat (2) @(posedge clk);
		if (errors == 0) begin
			$display("All tests passed");
		end else begin
			$display("Some tests failed");
		end
		$finish;
	end

endmodule
